/* hw/cpuPkg.sv */
// shared types and constants for the multi-cycle RV32I core
// widths, memory map, enums and bus structs
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  regIdx_t;

    // memory map
    localparam int    ramBytes   = 131072;
    localparam int    ramAddrW   = $clog2(ramBytes);
    localparam addr_t ioOutAddr  = 32'h0003_0000;
    localparam addr_t ioStopAddr = 32'h0003_0004;
    localparam addr_t resetPc    = 32'h0000_0000;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra,
        aluOr, aluAnd, aluBeq, aluBne, aluBlt, aluBge, aluBltu, aluBgeu
    } aluOp_e;

    typedef enum logic [1:0] {memByte, memByteU, memWord} memSize_e;

    typedef enum logic [3:0] {
        clsAlu, clsAluImm, clsLui, clsAuipc, clsJal, clsJalr,
        clsBranch, clsLoad, clsStore, clsIllegal
    } instClass_e;

    typedef enum logic [1:0] {stFetch, stExecute, stMemory, stWriteback} cpuState_e;

    typedef struct packed {
        instClass_e instClass;
        aluOp_e     aluOp;
        memSize_e   memSize;
        regIdx_t    rd;
        regIdx_t    rs1;
        regIdx_t    rs2;
        word_t      imm;
    } decodedInst_t;

    // byte bus toward the memory system
    typedef struct packed {
        addr_t addr;
        byte_t dout;
        logic  wr;
    } memBus_t;

    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        memSize_e size;
        logic     write;
    } memReq_t;

endpackage

/* hw/memCtrl.sv */
// memory controller: splits word and byte accesses into byte transfers
// on the 2-cycle-read byte bus
`timescale 1ns/10ps

module memCtrl (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            rdy,
    input  logic            reqValid,
    input  cpuPkg::memReq_t req,
    output logic            done,
    output cpuPkg::word_t   rdata,
    output cpuPkg::memBus_t memBus,
    input  cpuPkg::byte_t   mem_din
);

    logic             busy;
    logic [2:0]       cnt;
    logic [2:0]       nBytes;
    logic             lastStep;
    logic [23:0]      lowBytes;
    cpuPkg::memReq_t  curReq;

    assign nBytes   = (curReq.size == cpuPkg::memWord) ? 3'd4 : 3'd1;
    // reads finish one step later because of the bus latency
    assign lastStep = curReq.write ? (cnt == nBytes - 3'd1) : (cnt == nBytes);
    assign done     = busy && rdy && lastStep;

    assign memBus.addr = curReq.addr + cpuPkg::addr_t'(cnt);
    assign memBus.dout = curReq.wdata[{cnt[1:0], 3'b000} +: 8];
    assign memBus.wr   = busy && curReq.write && rdy;

    always_comb begin
        case (curReq.size)
            cpuPkg::memByte:  rdata = {{24{mem_din[7]}}, mem_din};
            cpuPkg::memByteU: rdata = {24'd0, mem_din};
            default:          rdata = {mem_din, lowBytes};
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (rdy) begin
            if (reqValid && !busy) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (lastStep) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

    // request copy and incoming bytes, shifted down so byte 0 lands lowest
    always_ff @(posedge clk_in) begin
        if (rdy) begin
            if (reqValid && !busy) begin
                curReq <= req;
            end
            if (busy) begin
                lowBytes <= {mem_din, lowBytes[23:8]};
            end
        end
    end

    // the core must wait for done before the next request
    reqWhileBusy: assert property (@(posedge clk_in) disable iff (reset) busy |-> !reqValid);

endmodule

/* hw/decoder.sv */
// instruction decoder that classifies an RV32I word and forms its immediate
`timescale 1ns/10ps

module decoder (
    input  cpuPkg::word_t        inst,
    output cpuPkg::decodedInst_t dec
);

    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          legalF7;
    cpuPkg::word_t immI;
    cpuPkg::word_t immS;
    cpuPkg::word_t immB;
    cpuPkg::word_t immU;
    cpuPkg::word_t immJ;

    function automatic cpuPkg::aluOp_e aluFromF3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? cpuPkg::aluSub : cpuPkg::aluAdd;
            3'b001:  return cpuPkg::aluSll;
            3'b010:  return cpuPkg::aluSlt;
            3'b011:  return cpuPkg::aluSltu;
            3'b100:  return cpuPkg::aluXor;
            3'b101:  return alt ? cpuPkg::aluSra : cpuPkg::aluSrl;
            3'b110:  return cpuPkg::aluOr;
            default: return cpuPkg::aluAnd;
        endcase
    endfunction

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    // only sub and sra carry the alternate funct7
    assign legalF7 = (funct7 == 7'h00)
                  || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'd0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec.instClass = cpuPkg::clsIllegal;
        dec.aluOp     = cpuPkg::aluAdd;
        dec.memSize   = cpuPkg::memWord;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = immI;
        case (inst[6:0])
            7'b0110111: begin
                dec.instClass = cpuPkg::clsLui;
                dec.imm       = immU;
            end
            7'b0010111: begin
                dec.instClass = cpuPkg::clsAuipc;
                dec.imm       = immU;
            end
            7'b1101111: begin
                dec.instClass = cpuPkg::clsJal;
                dec.imm       = immJ;
            end
            7'b1100111: begin
                if (funct3 == 3'b000) dec.instClass = cpuPkg::clsJalr;
            end
            7'b1100011: begin
                dec.imm = immB;
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    dec.instClass = cpuPkg::clsBranch;
                    // funct3 order follows the enum from beq onward
                    case (funct3)
                        3'b000:  dec.aluOp = cpuPkg::aluBeq;
                        3'b001:  dec.aluOp = cpuPkg::aluBne;
                        3'b100:  dec.aluOp = cpuPkg::aluBlt;
                        3'b101:  dec.aluOp = cpuPkg::aluBge;
                        3'b110:  dec.aluOp = cpuPkg::aluBltu;
                        default: dec.aluOp = cpuPkg::aluBgeu;
                    endcase
                end
            end
            7'b0000011: begin
                dec.instClass = cpuPkg::clsLoad;
                case (funct3)
                    3'b000:  dec.memSize = cpuPkg::memByte;
                    3'b100:  dec.memSize = cpuPkg::memByteU;
                    3'b010:  dec.memSize = cpuPkg::memWord;
                    default: dec.instClass = cpuPkg::clsIllegal;
                endcase
            end
            7'b0100011: begin
                dec.instClass = cpuPkg::clsStore;
                dec.imm       = immS;
                case (funct3)
                    3'b000:  dec.memSize = cpuPkg::memByte;
                    3'b010:  dec.memSize = cpuPkg::memWord;
                    default: dec.instClass = cpuPkg::clsIllegal;
                endcase
            end
            7'b0010011: begin
                dec.aluOp = aluFromF3(funct3, funct3 == 3'b101 && inst[30]);
                // shift amounts reuse the funct7 field
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (legalF7) begin
                        dec.instClass = cpuPkg::clsAluImm;
                    end
                end else begin
                    dec.instClass = cpuPkg::clsAluImm;
                end
            end
            7'b0110011: begin
                dec.aluOp = aluFromF3(funct3, inst[30]);
                if (legalF7) dec.instClass = cpuPkg::clsAlu;
            end
            default: ;
        endcase
    end

endmodule

/* hw/alu.sv */
// ALU with the RV32I arithmetic, logic and shift operations
// plus the branch condition for compare operations
`timescale 1ns/10ps

module alu (
    input  cpuPkg::aluOp_e op,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    output cpuPkg::word_t  result,
    output logic           taken
);

    logic       lessS;
    logic       lessU;
    logic [4:0] shamt;

    assign lessS = $signed(a) < $signed(b);
    assign lessU = a < b;
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpuPkg::aluAdd:  result = a + b;
            cpuPkg::aluSub:  result = a - b;
            cpuPkg::aluSll:  result = a << shamt;
            cpuPkg::aluSlt:  result = {31'd0, lessS};
            cpuPkg::aluSltu: result = {31'd0, lessU};
            cpuPkg::aluXor:  result = a ^ b;
            cpuPkg::aluSrl:  result = a >> shamt;
            cpuPkg::aluSra:  result = $signed(a) >>> shamt;
            cpuPkg::aluOr:   result = a | b;
            cpuPkg::aluAnd:  result = a & b;
            default:         result = '0;
        endcase
    end

    // compare ops only, everything else never branches
    always_comb begin
        case (op)
            cpuPkg::aluBeq:  taken = (a == b);
            cpuPkg::aluBne:  taken = (a != b);
            cpuPkg::aluBlt:  taken = lessS;
            cpuPkg::aluBge:  taken = !lessS;
            cpuPkg::aluBltu: taken = lessU;
            cpuPkg::aluBgeu: taken = !lessU;
            default:         taken = 1'b0;
        endcase
    end

endmodule

/* hw/regFile.sv */
// register file, 32 x 32 bits, two async reads and one sync write
`timescale 1ns/10ps

module regFile (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            rdy,
    input  cpuPkg::regIdx_t rs1,
    input  cpuPkg::regIdx_t rs2,
    input  cpuPkg::regIdx_t rd,
    input  logic            we,
    input  cpuPkg::word_t   wdata,
    output cpuPkg::word_t   rdata1,
    output cpuPkg::word_t   rdata2,
    output cpuPkg::word_t   a0
);

    cpuPkg::word_t regs [32];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy && we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];
    assign a0     = regs[10];

    zeroReg: assert property (@(posedge clk_in) disable iff (reset)
        (rs1 == 5'd0) |-> (rdata1 == '0));

endmodule

/* hw/cpu.sv */
// multi-cycle RV32I core, one instruction at a time
// fetch, execute, optional memory access, then writeback
`timescale 1ns/10ps

module cpu (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            rdy,
    input  logic            halted,
    output cpuPkg::memBus_t memBus,
    input  cpuPkg::byte_t   mem_din,
    output cpuPkg::word_t   dbgReg
);

    cpuPkg::cpuState_e    state;
    logic                 waiting;
    cpuPkg::addr_t        pc;
    cpuPkg::addr_t        nextPc;
    cpuPkg::word_t        instReg;
    cpuPkg::word_t        resultReg;
    cpuPkg::decodedInst_t dec;
    cpuPkg::word_t        rs1Val;
    cpuPkg::word_t        rs2Val;
    cpuPkg::word_t        aluA;
    cpuPkg::word_t        aluB;
    cpuPkg::word_t        aluResult;
    logic                 taken;
    cpuPkg::memReq_t      req;
    logic                 reqValid;
    logic                 done;
    cpuPkg::word_t        rdata;
    logic                 isJump;
    logic                 memAccess;
    logic                 writesRd;
    cpuPkg::addr_t        pcPlus4;

    assign isJump    = dec.instClass inside {cpuPkg::clsJal, cpuPkg::clsJalr};
    assign memAccess = dec.instClass inside {cpuPkg::clsLoad, cpuPkg::clsStore};
    assign writesRd  = !(dec.instClass inside {cpuPkg::clsBranch, cpuPkg::clsStore,
                                               cpuPkg::clsIllegal});
    assign pcPlus4   = pc + 32'd4;

    // one request per fetch or memory phase, none once stopped
    assign reqValid = ((state == cpuPkg::stFetch && !halted) || state == cpuPkg::stMemory)
                   && !waiting;

    always_comb begin
        req.addr  = (state == cpuPkg::stFetch) ? pc : resultReg;
        req.wdata = rs2Val;
        req.size  = (state == cpuPkg::stFetch) ? cpuPkg::memWord : dec.memSize;
        req.write = (state == cpuPkg::stMemory) && (dec.instClass == cpuPkg::clsStore);
    end

    // operand select, lui is 0 + imm
    always_comb begin
        if (dec.instClass inside {cpuPkg::clsAuipc, cpuPkg::clsJal}) begin
            aluA = pc;
        end else if (dec.instClass == cpuPkg::clsLui) begin
            aluA = '0;
        end else begin
            aluA = rs1Val;
        end
        aluB = (dec.instClass inside {cpuPkg::clsAlu, cpuPkg::clsBranch}) ? rs2Val : dec.imm;
    end

    memCtrl memCtrl_i (
        .clk_in(clk_in), .reset(reset), .rdy(rdy),
        .reqValid(reqValid), .req(req), .done(done), .rdata(rdata),
        .memBus(memBus), .mem_din(mem_din)
    );

    decoder decoder_i (.inst(instReg), .dec(dec));

    alu alu_i (.op(dec.aluOp), .a(aluA), .b(aluB), .result(aluResult), .taken(taken));

    regFile regFile_i (
        .clk_in(clk_in), .reset(reset), .rdy(rdy),
        .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .we(state == cpuPkg::stWriteback && writesRd), .wdata(resultReg),
        .rdata1(rs1Val), .rdata2(rs2Val), .a0(dbgReg)
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state   <= cpuPkg::stFetch;
            waiting <= 1'b0;
            pc      <= cpuPkg::resetPc;
        end else if (rdy) begin
            case (state)
                cpuPkg::stFetch, cpuPkg::stMemory: begin
                    if (done) begin
                        waiting <= 1'b0;
                        state   <= (state == cpuPkg::stFetch) ? cpuPkg::stExecute
                                                              : cpuPkg::stWriteback;
                    end else if (reqValid) begin
                        waiting <= 1'b1;
                    end
                end
                cpuPkg::stExecute: begin
                    state <= memAccess ? cpuPkg::stMemory : cpuPkg::stWriteback;
                end
                default: begin
                    pc    <= nextPc;
                    state <= cpuPkg::stFetch;
                end
            endcase
        end
    end

    // instruction, result and next pc
    always_ff @(posedge clk_in) begin
        if (rdy) begin
            if (state == cpuPkg::stFetch && done) begin
                instReg <= rdata;
            end
            if (state == cpuPkg::stMemory && done) begin
                resultReg <= rdata;
            end
            if (state == cpuPkg::stExecute) begin
                resultReg <= isJump ? pcPlus4 : aluResult;
                case (dec.instClass)
                    cpuPkg::clsJal:    nextPc <= aluResult;
                    cpuPkg::clsJalr:   nextPc <= aluResult & ~32'd1;
                    cpuPkg::clsBranch: nextPc <= taken ? pc + dec.imm : pcPlus4;
                    default:           nextPc <= pcPlus4;
                endcase
            end
        end
    end

    pcAligned: assert property (@(posedge clk_in) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* hw/memSystem.sv */
// memory system: 128 KB byte RAM, character output and stop register
`timescale 1ns/10ps

module memSystem (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            rdy,
    input  cpuPkg::memBus_t memBus,
    output cpuPkg::byte_t   mem_din,
    input  logic            loadEn,
    input  cpuPkg::addr_t   loadAddr,
    input  cpuPkg::byte_t   loadData,
    output logic            outValid,
    output cpuPkg::byte_t   outByte,
    output logic            halted
);

    cpuPkg::byte_t ram [cpuPkg::ramBytes];
    logic          isIo;
    logic          inRam;
    logic          outWrite;
    logic          stopWrite;

    assign isIo      = memBus.addr[17:16] == 2'b11;
    assign inRam     = memBus.addr < cpuPkg::addr_t'(cpuPkg::ramBytes);
    // zero bytes to the output port are dropped
    assign outWrite  = memBus.wr && isIo && memBus.addr[2:0] == cpuPkg::ioOutAddr[2:0]
                    && memBus.dout != 8'd0;
    assign stopWrite = memBus.wr && isIo && memBus.addr[2:0] == cpuPkg::ioStopAddr[2:0];

    always_ff @(posedge clk_in) begin
        if (loadEn) begin
            ram[loadAddr[cpuPkg::ramAddrW-1:0]] <= loadData;
        end else if (memBus.wr && inRam) begin
            ram[memBus.addr[cpuPkg::ramAddrW-1:0]] <= memBus.dout;
        end
        // read data holds while the core is frozen
        if (rdy) begin
            mem_din <= ram[memBus.addr[cpuPkg::ramAddrW-1:0]];
        end
        if (outWrite) begin
            outByte <= memBus.dout;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            outValid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            outValid <= outWrite;
            if (stopWrite) halted <= 1'b1;
        end
    end

endmodule

/* hw/socTop.sv */
// top level, core plus memory system
`timescale 1ns/10ps

module socTop (
    input  logic          clk_in,
    input  logic          reset,
    input  logic          rdy,
    input  logic          loadEn,
    input  cpuPkg::addr_t loadAddr,
    input  cpuPkg::byte_t loadData,
    output logic          outValid,
    output cpuPkg::byte_t outByte,
    output logic          halted,
    output cpuPkg::word_t dbgReg
);

    cpuPkg::memBus_t memBus;
    cpuPkg::byte_t   mem_din;

    cpu cpu_i (
        .clk_in(clk_in),
        .reset(reset),
        .rdy(rdy),
        .halted(halted),
        .memBus(memBus),
        .mem_din(mem_din),
        .dbgReg(dbgReg)
    );

    memSystem memSystem_i (
        .clk_in(clk_in),
        .reset(reset),
        .rdy(rdy),
        .memBus(memBus),
        .mem_din(mem_din),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .outValid(outValid),
        .outByte(outByte),
        .halted(halted)
    );

endmodule

/* test/clockGen.sv */
// clock and power-on reset for the SoC testbench
`timescale 1ns/10ps

module clockGen (
    output logic clk_in,
    output logic reset
);

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    // reset held for 8 cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
    end

endmodule

/* test/tbSoc.sv */
// SoC testbench with a random RV32I program, an ISA model and an output stream checker
`timescale 1ns/10ps

module tbSoc;

    logic          clk_in;
    logic          genReset;
    logic          hostReset;
    logic          rdy;
    logic          loadEn;
    cpuPkg::addr_t loadAddr;
    cpuPkg::byte_t loadData;
    logic          outValid;
    cpuPkg::byte_t outByte;
    logic          halted;
    cpuPkg::word_t dbgReg;

    cpuPkg::word_t prog [256];
    int            progLen;
    cpuPkg::byte_t modelMem [cpuPkg::ramBytes];
    cpuPkg::byte_t expQ [$];
    cpuPkg::word_t expA0;
    int            expCount;
    logic [31:0]   rngState;
    logic [31:0]   rdyState;
    string         testName;
    int            seen;
    int            cycles;
    int            limit;
    logic          running;
    logic          randRdy;

    clockGen clockGen_i (.clk_in(clk_in), .reset(genReset));

    socTop dut_i (
        .clk_in(clk_in), .reset(genReset | hostReset), .rdy(rdy),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .outValid(outValid), .outByte(outByte), .halted(halted), .dbgReg(dbgReg)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // instruction encoders for the RV32I formats
    function automatic cpuPkg::word_t encR(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic cpuPkg::word_t encI(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic cpuPkg::word_t encS(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic cpuPkg::word_t encB(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic cpuPkg::word_t encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic put(input cpuPkg::word_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic putBranchBack(input int target, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        put(encB(13'((target - progLen) * 4), rs2, rs1, f3));
    endtask

    // x11 holds the output port and x12 a RAM scratch area
    task automatic buildProgram();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          top;
        progLen = 0;
        put({20'h00030, 5'd11, 7'h37});
        put({20'h00001, 5'd12, 7'h37});
        for (int i = 1; i <= 9; i++) begin
            r = nextRand();
            put({r[31:12], 5'(i), 7'h37});
            put(encI(r[11:0], 5'(i), 3'd0, 5'(i), 7'h13));
        end
        put({nextRand() & 32'hffff_f000} | 32'h417);
        // auipc result emitted a byte at a time
        for (int sh = 0; sh < 32; sh += 8) begin
            put(encI(12'(sh), 5'd8, 3'd5, 5'd16, 7'h13));
            put(encS(12'd0, 5'd16, 5'd11, 3'd0));
        end
        for (int k = 0; k < 24; k++) begin
            r  = nextRand();
            f3 = r[3:1];
            rd = 5'(1 + r[7:4] % 9);
            if (r[0]) begin
                imm = r[27:16];
                if (f3 == 3'd1) imm = {7'h00, r[20:16]};
                if (f3 == 3'd5) imm = {r[17] ? 7'h20 : 7'h00, r[22:18]};
                put(encI(imm, 5'(r[11:8] % 10), f3, rd, 7'h13));
            end else begin
                put(encR((f3 == 3'd0 || f3 == 3'd5) && r[16] ? 7'h20 : 7'h00,
                    5'(r[15:12] % 10), 5'(r[11:8] % 10), f3, rd));
            end
            put(encS(12'd0, rd, 5'd11, 3'd0));
        end
        // RAM round trip with word and byte accesses
        put(encS(12'd0, 5'd1, 5'd12, 3'd2));
        put(encS(12'd4, 5'd2, 5'd12, 3'd2));
        put(encS(12'd6, 5'd3, 5'd12, 3'd0));
        put(encS(12'd7, 5'd1, 5'd12, 3'd0));
        put(encI(12'd0, 5'd12, 3'd2, 5'd4, 7'h03));
        put(encI(12'd6, 5'd12, 3'd0, 5'd5, 7'h03));
        put(encI(12'd7, 5'd12, 3'd4, 5'd6, 7'h03));
        put(encI(12'd4, 5'd12, 3'd2, 5'd7, 7'h03));
        for (int reg4 = 4; reg4 <= 7; reg4++) begin
            for (int sh = 0; sh < 32; sh += 8) begin
                put(encI(12'(sh), 5'(reg4), 3'd5, 5'd9, 7'h13));
                put(encS(12'd0, 5'd9, 5'd11, 3'd0));
            end
        end
        // writes to x0 are lost
        put(encI(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));
        put(encS(12'd0, 5'd0, 5'd11, 3'd0));
        // counted loops with bne down and blt up
        put(encI(12'(3 + nextRand() % 4), 5'd0, 3'd0, 5'd13, 7'h13));
        put(encI(12'h041, 5'd0, 3'd0, 5'd14, 7'h13));
        top = progLen;
        put(encI(12'd1, 5'd14, 3'd0, 5'd14, 7'h13));
        put(encS(12'd0, 5'd14, 5'd11, 3'd0));
        put(encI(12'hfff, 5'd13, 3'd0, 5'd13, 7'h13));
        putBranchBack(top, 5'd0, 5'd13, 3'd1);
        put(encI(12'(2 + nextRand() % 4), 5'd0, 3'd0, 5'd15, 7'h13));
        top = progLen;
        put(encI(12'd1, 5'd13, 3'd0, 5'd13, 7'h13));
        put(encS(12'd0, 5'd13, 5'd11, 3'd0));
        putBranchBack(top, 5'd15, 5'd13, 3'd4);
        // jal and jalr skip over stores and emit their links
        put(encJ(21'd8, 5'd1));
        put(encS(12'd0, 5'd14, 5'd11, 3'd0));
        put(encS(12'd0, 5'd1, 5'd11, 3'd0));
        put({20'h00000, 5'd6, 7'h17});
        put(encI(12'd16, 5'd6, 3'd0, 5'd7, 7'h67));
        put(encS(12'd0, 5'd14, 5'd11, 3'd0));
        put(encS(12'd0, 5'd14, 5'd11, 3'd0));
        put(encS(12'd0, 5'd7, 5'd11, 3'd0));
        put(encR(7'h00, 5'd7, 5'd4, 3'd0, 5'd10));
        put(encS(12'd4, 5'd0, 5'd11, 3'd0));
        put(encJ(21'd0, 5'd0));
    endtask

    function automatic cpuPkg::word_t aluRef(input logic [2:0] f3, input logic alt,
            input cpuPkg::word_t a, input cpuPkg::word_t b);
        cpuPkg::word_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'd0, $signed(a) < $signed(b)};
            3'd3: res = {31'd0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // ISA model filling expQ and expA0 and returning the instruction count
    function int runModel();
        cpuPkg::word_t x [32];
        cpuPkg::word_t pc;
        cpuPkg::word_t inst;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t res;
        cpuPkg::word_t addr;
        cpuPkg::word_t nextPc;
        cpuPkg::word_t immI;
        cpuPkg::word_t immS;
        cpuPkg::word_t immB;
        logic [2:0]    f3;
        logic          wr;
        logic          tk;
        logic          stop;
        int            count;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < progLen * 4; i++) modelMem[i] = prog[i / 4][8 * (i % 4) +: 8];
        expQ.delete();
        pc    = '0;
        count = 0;
        stop  = 1'b0;
        while (!stop && count < 10000) begin
            inst   = {modelMem[pc + 3], modelMem[pc + 2], modelMem[pc + 1], modelMem[pc]};
            count++;
            f3     = inst[14:12];
            a      = x[inst[19:15]];
            b      = x[inst[24:20]];
            immI   = {{20{inst[31]}}, inst[31:20]};
            immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            immB   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            nextPc = pc + 4;
            wr     = 1'b1;
            res    = '0;
            case (inst[6:0])
                7'h37: res = {inst[31:12], 12'd0};
                7'h17: res = pc + {inst[31:12], 12'd0};
                7'h6f: begin
                    res    = pc + 4;
                    nextPc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                   inst[30:21], 1'b0};
                end
                7'h67: begin
                    res    = pc + 4;
                    nextPc = (a + immI) & ~32'd1;
                end
                7'h63: begin
                    wr = 1'b0;
                    case (f3)
                        3'd0: tk = a == b;
                        3'd1: tk = a != b;
                        3'd4: tk = $signed(a) < $signed(b);
                        3'd5: tk = $signed(a) >= $signed(b);
                        3'd6: tk = a < b;
                        default: tk = a >= b;
                    endcase
                    if (tk) nextPc = pc + immB;
                end
                7'h03: begin
                    addr = a + immI;
                    res  = {24'd0, modelMem[addr[16:0]]};
                    if (f3 == 3'd0) res = {{24{res[7]}}, res[7:0]};
                    if (f3 == 3'd2) begin
                        res = {modelMem[addr[16:0] + 3], modelMem[addr[16:0] + 2],
                               modelMem[addr[16:0] + 1], modelMem[addr[16:0]]};
                    end
                end
                7'h23: begin
                    wr   = 1'b0;
                    addr = a + immS;
                    if (addr == cpuPkg::ioStopAddr) begin
                        stop = 1'b1;
                    end else if (addr == cpuPkg::ioOutAddr) begin
                        if (b[7:0] != 8'd0) expQ.push_back(b[7:0]);
                    end else begin
                        for (int i = 0; i < ((f3 == 3'd2) ? 4 : 1); i++) begin
                            modelMem[addr[16:0] + 17'(i)] = b[8 * i +: 8];
                        end
                    end
                end
                7'h13: res = aluRef(f3, f3 == 3'd5 && inst[30], a, immI);
                default: res = aluRef(f3, inst[30], a, b);
            endcase
            if (wr && inst[11:7] != 5'd0) x[inst[11:7]] = res;
            pc = nextPc;
        end
        expA0 = x[10];
        return count;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "test %s failed", testName);
    endtask

    // host port writes the program one byte per cycle
    task automatic loadProgram();
        for (int i = 0; i < progLen * 4; i++) begin
            @(negedge clk_in);
            loadEn   = 1'b1;
            loadAddr = cpuPkg::addr_t'(i);
            loadData = prog[i / 4][8 * (i % 4) +: 8];
        end
        @(negedge clk_in);
        loadEn = 1'b0;
    endtask

    task automatic runProgram(input string name, input logic stall);
        hostReset = 1'b1;
        randRdy   = 1'b0;
        rdy       = 1'b1;
        loadProgram();
        while (genReset) @(negedge clk_in);
        testName  = name;
        seen      = 0;
        cycles    = 0;
        limit     = expCount * 40 * 2;
        hostReset = 1'b0;
        running   = 1'b1;
        randRdy   = stall;
        while (!halted) @(negedge clk_in);
        running = 1'b0;
        randRdy = 1'b0;
        rdy     = 1'b1;
        assert (seen == expQ.size()) else
            failRun($sformatf("mismatch %s byte count expected %0d actual %0d",
                name, expQ.size(), seen));
        assert (dbgReg == expA0) else
            failRun($sformatf("mismatch %s a0 expected %h actual %h", name, expA0, dbgReg));
    endtask

    // output stream comparison sampled mid-cycle
    always @(negedge clk_in) begin
        if (running && outValid) begin
            assert (seen < expQ.size() && outByte == expQ[seen]) else
                failRun($sformatf("mismatch %s byte %0d expected %h actual %h", testName,
                    seen, (seen < expQ.size()) ? expQ[seen] : 8'hxx, outByte));
            seen++;
        end
    end

    always @(negedge clk_in) begin
        if (randRdy) begin
            rdyState = xorshift(rdyState);
            rdy      = rdyState[1:0] != 2'b00;
        end
    end

    always @(negedge clk_in) begin
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                failRun($sformatf("test %s timed out, the program did not halt", testName));
            end
        end
    end

    initial begin
        hostReset = 1'b1;
        rdy       = 1'b1;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        running   = 1'b0;
        randRdy   = 1'b0;
        rngState  = 32'h8e59;
        rdyState  = xorshift(32'h8e59);
        testName  = "setup";
        buildProgram();
        expCount = runModel();
        runProgram("baseline", 1'b0);
        runProgram("rdyStall", 1'b1);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* project.f */
+incdir+test
hw/cpuPkg.sv
hw/memCtrl.sv
hw/decoder.sv
hw/alu.sv
hw/regFile.sv
hw/cpu.sv
hw/memSystem.sv
hw/socTop.sv
test/clockGen.sv
test/tbSoc.sv

/* run.sh */
#!/usr/bin/env bash
# build the SoC testbench with Verilator and run it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tbSoc \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0
